/* Bender.yml */
package:
  name: vsa_system

sources:
  # shared package first
  - files:
      - common/vsaPkg.sv
  # design
  - files:
      - hw/vsaCore/vsaAlu.sv
      - hw/vsaCore/vsaCore.sv
      - hw/progMem.sv
      - hw/dataMem.sv
      - hw/vsaSystem.sv
  # verification
  - target: test
    files:
      - verif/vsaCore_properties.sv
      - verif/vsaSystemTb.sv

/* build.f */
common/vsaPkg.sv
hw/vsaCore/vsaAlu.sv
hw/vsaCore/vsaCore.sv
hw/progMem.sv
hw/dataMem.sv
hw/vsaSystem.sv
verif/vsaCore_properties.sv
verif/vsaSystemTb.sv

/* common/vsaPkg.sv */
// shared sizes, instruction field positions and enums
// for the 12-bit VSA core, its memories and testbench
`default_nettype none

package vsaPkg;

    // word and memory sizes, fixed by the encoding
    localparam int dataWidth    = 5;
    localparam int instrWidth   = 12;
    localparam int pcWidth      = 5;
    localparam int progDepth    = 16;                 // word k at pc 2k
    localparam int progAddrWidth = $clog2(progDepth);
    localparam int dataDepth    = 32;
    localparam int regCount     = 4;                  // r0 hard-wired zero
    localparam int regAddrWidth = $clog2(regCount);

    // instruction field positions
    localparam int opMsb   = 11;
    localparam int opLsb   = 9;
    localparam int src1Msb = 8;
    localparam int src1Lsb = 7;
    localparam int src2Msb = 6;                       // also I-format dest
    localparam int src2Lsb = 5;
    localparam int dstMsb  = 4;                       // R-format only
    localparam int dstLsb  = 3;
    localparam int funcMsb = 2;
    localparam int funcLsb = 0;
    localparam int immMsb  = 4;
    localparam int immLsb  = 0;

    // one state per cycle, five per instruction
    typedef enum logic [2:0] {
        stFetch     = 3'd0,
        stDecode    = 3'd1,
        stExecute   = 3'd2,
        stMemory    = 3'd3,
        stWriteBack = 3'd4
    } stateT;

    typedef enum logic [2:0] {
        opLw   = 3'd0,
        opSw   = 3'd1,
        opBeqz = 3'd2,
        opAlu  = 3'd3,                                // R-format, see func
        opAddi = 3'd4,
        opSubi = 3'd5
    } opcodeT;

    typedef enum logic [2:0] {
        fnAdd = 3'd0,
        fnSub = 3'd1,
        fnAnd = 3'd2,
        fnOr  = 3'd3,
        fnXor = 3'd4,
        fnNot = 3'd5,
        fnSrl = 3'd6,
        fnSra = 3'd7
    } aluFuncT;

    // operand form for the ALU
    typedef enum logic [1:0] {
        selReg    = 2'd0,                             // a op b
        selImm    = 2'd1,                             // a +/- imm
        selAddr   = 2'd2,                             // a + imm, load/store
        selBranch = 2'd3                              // npc + 2*imm
    } aluSelT;

endpackage

`default_nettype wire

/* hw/dataMem.sv */
// data memory, 32 words of 5 bits
// cleared on reset, strobed write, combinational read
`timescale 1ns/1ps
`default_nettype none

module dataMem (
    input  wire logic                         clock,
    input  wire logic                         rst,
    input  wire logic                         memWrite,
    input  wire logic [vsaPkg::dataWidth-1:0] memAddr,
    input  wire logic [vsaPkg::dataWidth-1:0] memWriteData,
    output logic      [vsaPkg::dataWidth-1:0] memReadData
);

    logic [vsaPkg::dataWidth-1:0] mem [vsaPkg::dataDepth];

    always_ff @(posedge clock) begin
        if (rst) begin
            // untouched words read back as 0
            for (int i = 0; i < vsaPkg::dataDepth; i++) begin
                mem[i] <= '0;
            end
        end else if (memWrite) begin
            mem[memAddr] <= memWriteData;  // SW strobe from the core
        end
    end

    assign memReadData = mem[memAddr];  // address is the ALU output reg

endmodule

`default_nettype wire

/* hw/progMem.sv */
// instruction memory, 16 words of 12 bits
// load port for the testbench, read port addressed by pc
`timescale 1ns/1ps
`default_nettype none

module progMem (
    input  wire logic                             clock,
    input  wire logic                             progWrite,
    input  wire logic [vsaPkg::progAddrWidth-1:0] progAddr,
    input  wire logic [vsaPkg::instrWidth-1:0]    progData,
    input  wire logic [vsaPkg::pcWidth-1:0]       pc,
    output logic      [vsaPkg::instrWidth-1:0]    instruction
);

    logic [vsaPkg::instrWidth-1:0] mem [vsaPkg::progDepth];  // loaded, never reset

    always_ff @(posedge clock) begin
        if (progWrite) begin
            mem[progAddr] <= progData;
        end
    end

    // pc steps by two, drop bit 0
    assign instruction = mem[pc[vsaPkg::pcWidth-1:1]];

endmodule

`default_nettype wire

/* hw/vsaCore/vsaAlu.sv */
// combinational ALU for register, immediate, address and branch target forms
`timescale 1ns/1ps
`default_nettype none

module vsaAlu (
    input  wire logic [vsaPkg::dataWidth-1:0] a,
    input  wire logic [vsaPkg::dataWidth-1:0] b,
    input  wire logic [vsaPkg::pcWidth-1:0]   npc,
    input  wire logic [vsaPkg::dataWidth-1:0] imm,
    input  wire vsaPkg::aluSelT                sel,
    input  wire vsaPkg::aluFuncT               func,
    input  wire logic                          immSub,   // SUBI
    output logic      [vsaPkg::dataWidth-1:0] result,
    output logic                               isZero
);

    logic [vsaPkg::dataWidth-1:0] regResult;  // R-format result
    logic [vsaPkg::dataWidth-1:0] immResult;

    // register-register functions
    always_comb begin
        case (func)
            vsaPkg::fnAdd: regResult = a + b;
            vsaPkg::fnSub: regResult = a - b;
            vsaPkg::fnAnd: regResult = a & b;
            vsaPkg::fnOr:  regResult = a | b;
            vsaPkg::fnXor: regResult = a ^ b;
            vsaPkg::fnNot: regResult = ~a;                 // b ignored
            vsaPkg::fnSrl: regResult = {1'b0, a[vsaPkg::dataWidth-1:1]};
            vsaPkg::fnSra: regResult = {a[vsaPkg::dataWidth-1], a[vsaPkg::dataWidth-1:1]};
            default:       regResult = a + b;
        endcase
    end

    assign immResult = immSub ? a - imm : a + imm;

    // pick operand form
    always_comb begin
        case (sel)
            vsaPkg::selReg:    result = regResult;
            vsaPkg::selImm:    result = immResult;
            vsaPkg::selAddr:   result = a + imm;           // no sign extension
            vsaPkg::selBranch: result = npc + {imm[vsaPkg::dataWidth-2:0], 1'b0};
            default:           result = regResult;
        endcase
    end

    // BEQZ tests the first source only
    assign isZero = (a == '0);

endmodule

`default_nettype wire

/* hw/vsaCore/vsaCore.sv */
// non-pipelined VSA core: five-state control FSM, instruction register,
// register file with r0 tied to zero, program counter stepping by two
`timescale 1ns/1ps
`default_nettype none

module vsaCore (
    input  wire logic                          clock,
    input  wire logic                          rst,
    input  wire logic                          run,          // low holds in fetch
    input  wire logic [vsaPkg::instrWidth-1:0] instruction,
    input  wire logic [vsaPkg::dataWidth-1:0]  memReadData,
    output logic      [vsaPkg::pcWidth-1:0]    pc,
    output logic      [vsaPkg::dataWidth-1:0]  memAddr,
    output logic      [vsaPkg::dataWidth-1:0]  memWriteData,
    output logic                               memWrite
);

    vsaPkg::stateT   state;
    vsaPkg::opcodeT  opcode;
    vsaPkg::aluFuncT aluFunc;
    vsaPkg::aluSelT  aluSel;

    logic [vsaPkg::dataWidth-1:0]    regFile [vsaPkg::regCount];
    logic [vsaPkg::instrWidth-1:0]   ir;         // instruction register
    logic [vsaPkg::pcWidth-1:0]      npc;        // pc + 2, captured in fetch
    logic [vsaPkg::dataWidth-1:0]    opA;
    logic [vsaPkg::dataWidth-1:0]    opB;
    logic [vsaPkg::dataWidth-1:0]    aluOut;     // doubles as data address
    logic                            cond;       // branch taken
    logic [vsaPkg::dataWidth-1:0]    lmd;        // load data
    logic [vsaPkg::dataWidth-1:0]    aluResult;
    logic                            aluZero;
    logic [vsaPkg::regAddrWidth-1:0] src1;
    logic [vsaPkg::regAddrWidth-1:0] src2;
    logic [vsaPkg::regAddrWidth-1:0] dst;
    logic [vsaPkg::dataWidth-1:0]    imm;
    logic                            wbEn;
    logic [vsaPkg::regAddrWidth-1:0] wbAddr;
    logic [vsaPkg::dataWidth-1:0]    wbData;

    // instruction fields
    assign opcode  = vsaPkg::opcodeT'(ir[vsaPkg::opMsb:vsaPkg::opLsb]);
    assign src1    = ir[vsaPkg::src1Msb:vsaPkg::src1Lsb];
    assign src2    = ir[vsaPkg::src2Msb:vsaPkg::src2Lsb];
    assign dst     = ir[vsaPkg::dstMsb:vsaPkg::dstLsb];
    assign aluFunc = vsaPkg::aluFuncT'(ir[vsaPkg::funcMsb:vsaPkg::funcLsb]);
    assign imm     = ir[vsaPkg::immMsb:vsaPkg::immLsb];

    // operand form from opcode
    always_comb begin
        case (opcode)
            vsaPkg::opLw, vsaPkg::opSw:     aluSel = vsaPkg::selAddr;
            vsaPkg::opBeqz:                 aluSel = vsaPkg::selBranch;
            vsaPkg::opAddi, vsaPkg::opSubi: aluSel = vsaPkg::selImm;
            default:                        aluSel = vsaPkg::selReg;
        endcase
    end

    vsaAlu alu_i (
        .a      (opA),
        .b      (opB),
        .npc    (npc),
        .imm    (imm),
        .sel    (aluSel),
        .func   (aluFunc),
        .immSub (opcode == vsaPkg::opSubi),
        .result (aluResult),
        .isZero (aluZero)
    );

    // write-back target: R-format uses dst, I-format uses src2
    always_comb begin
        wbEn   = 1'b0;
        wbAddr = src2;
        wbData = aluOut;
        case (opcode)
            vsaPkg::opAlu: begin
                wbEn   = 1'b1;
                wbAddr = dst;
            end
            vsaPkg::opAddi, vsaPkg::opSubi: wbEn = 1'b1;
            vsaPkg::opLw: begin
                wbEn   = 1'b1;
                wbData = lmd;
            end
            default: wbEn = 1'b0;                       // SW, BEQZ
        endcase
    end

    // control state
    always_ff @(posedge clock) begin
        if (rst) begin
            state <= vsaPkg::stFetch;
            pc    <= '0;
            for (int i = 0; i < vsaPkg::regCount; i++) begin
                regFile[i] <= '0;
            end
        end else begin
            case (state)
                vsaPkg::stFetch: begin
                    if (run) state <= vsaPkg::stDecode;  // park while loading
                end
                vsaPkg::stDecode:  state <= vsaPkg::stExecute;
                vsaPkg::stExecute: state <= vsaPkg::stMemory;
                vsaPkg::stMemory: begin
                    state <= vsaPkg::stWriteBack;
                    // taken branch only for BEQZ
                    if (opcode == vsaPkg::opBeqz && cond) begin
                        pc <= aluOut;
                    end else begin
                        pc <= npc;
                    end
                end
                vsaPkg::stWriteBack: begin
                    state <= vsaPkg::stFetch;
                    if (wbEn && wbAddr != '0) regFile[wbAddr] <= wbData;  // r0 stays 0
                end
                default: state <= vsaPkg::stFetch;
            endcase
        end
    end

    // datapath registers, no reset
    always_ff @(posedge clock) begin
        case (state)
            vsaPkg::stFetch: begin
                if (run) begin
                    ir  <= instruction;
                    npc <= pc + vsaPkg::pcWidth'(2);
                end
            end
            vsaPkg::stDecode: begin
                opA <= regFile[src1];
                opB <= regFile[src2];
            end
            vsaPkg::stExecute: begin
                aluOut <= aluResult;
                cond   <= aluZero;                       // only read by BEQZ
            end
            vsaPkg::stMemory: begin
                if (opcode == vsaPkg::opLw) lmd <= memReadData;
            end
            default: ;
        endcase
    end

    // store bus
    assign memAddr      = aluOut;
    assign memWriteData = opB;
    assign memWrite     = (state == vsaPkg::stMemory) && (opcode == vsaPkg::opSw);

endmodule

`default_nettype wire

/* hw/vsaSystem.sv */
// top level: program memory feeding the core, core driving data memory
`timescale 1ns/1ps
`default_nettype none

module vsaSystem (
    input  wire logic                             clock,
    input  wire logic                             rst,
    input  wire logic                             run,
    input  wire logic                             progWrite,   // load port
    input  wire logic [vsaPkg::progAddrWidth-1:0] progAddr,
    input  wire logic [vsaPkg::instrWidth-1:0]    progData,
    output logic      [vsaPkg::pcWidth-1:0]       pc,
    output logic                                  memWrite,    // store bus
    output logic      [vsaPkg::dataWidth-1:0]     memAddr,
    output logic      [vsaPkg::dataWidth-1:0]     memWriteData
);

    logic [vsaPkg::instrWidth-1:0] instruction;
    logic [vsaPkg::dataWidth-1:0]  memReadData;

    progMem progMem_i (
        .clock       (clock),
        .progWrite   (progWrite),
        .progAddr    (progAddr),
        .progData    (progData),
        .pc          (pc),
        .instruction (instruction)
    );

    vsaCore vsaCore_i (
        .clock        (clock),
        .rst          (rst),
        .run          (run),
        .instruction  (instruction),
        .memReadData  (memReadData),
        .pc           (pc),
        .memAddr      (memAddr),
        .memWriteData (memWriteData),
        .memWrite     (memWrite)
    );

    dataMem dataMem_i (
        .clock        (clock),
        .rst          (rst),
        .memWrite     (memWrite),
        .memAddr      (memAddr),
        .memWriteData (memWriteData),
        .memReadData  (memReadData)
    );

endmodule

`default_nettype wire

/* verif/vsaCore_properties.sv */
// concurrent assertions on the core FSM, pc, r0 and the store strobe
`timescale 1ns/1ps
`default_nettype none

module vsaCoreProperties (
    input wire logic                         clock,
    input wire logic                         rst,
    input wire vsaPkg::stateT                state,
    input wire logic [vsaPkg::pcWidth-1:0]   pc,
    input wire logic [vsaPkg::dataWidth-1:0] reg0,
    input wire logic                         memWrite
);

    int assertFails = 0;  // failure count, read by the testbench

    strobeInMemory: assert property (@(posedge clock) disable iff (rst)
        memWrite |-> state == vsaPkg::stMemory)
    else begin
        $error("memWrite high outside stMemory");
        assertFails++;
    end

    pcEven: assert property (@(posedge clock) disable iff (rst) pc[0] == 1'b0)
    else begin
        $error("pc is odd");
        assertFails++;
    end

    // hard-wired zero register
    regZeroHeld: assert property (@(posedge clock) disable iff (rst) reg0 == '0)
    else begin
        $error("register 0 is not zero");
        assertFails++;
    end

    writeBackToFetch: assert property (@(posedge clock) disable iff (rst)
        state == vsaPkg::stWriteBack |=> state == vsaPkg::stFetch)
    else begin
        $error("stWriteBack not followed by stFetch");
        assertFails++;
    end

endmodule

bind vsaCore vsaCoreProperties props_i (
    .clock    (clock),
    .rst      (rst),
    .state    (state),
    .pc       (pc),
    .reg0     (regFile[0]),
    .memWrite (memWrite)
);

`default_nettype wire

/* verif/vsaSystemTb.sv */
// testbench for vsaSystem with program table, LFSR immediates and reference model
// store bus and pc checks against the model, watchdog
`timescale 1ns/1ps
`default_nettype none

module vsaSystemTb;

    localparam int numRows    = 5;
    localparam int progWords  = vsaPkg::progDepth;
    localparam int tailInstr  = 2;                      // halt loops after the last store
    localparam int rowSetup   = 10 + progWords + 4;     // reset, load, slack
    localparam int watchdogNs = numRows * (progWords * 5 + rowSetup) * 4 + 400;

    logic                             clock;
    logic                             rst;
    logic                             run;
    logic                             progWrite;
    logic [vsaPkg::progAddrWidth-1:0] progAddr;
    logic [vsaPkg::instrWidth-1:0]    progData;
    logic [vsaPkg::pcWidth-1:0]       pc;
    logic                             memWrite;
    logic [vsaPkg::dataWidth-1:0]     memAddr;
    logic [vsaPkg::dataWidth-1:0]     memWriteData;

    logic [vsaPkg::instrWidth-1:0] progTable [numRows][progWords];
    logic [7:0]                    lfsr;

    // expected stores of the current row
    logic [vsaPkg::dataWidth-1:0] expAddr [$];
    logic [vsaPkg::dataWidth-1:0] expData [$];
    int                           expCycle [$];
    int                           execCount;   // instructions up to the first halt
    logic [vsaPkg::pcWidth-1:0]   haltPc;

    int checks = 0;
    int valueErrs = 0;
    int seqErrs = 0;
    int assertErrs = 0;

    vsaSystem vsaSystem_i (
        .clock        (clock),
        .rst          (rst),
        .run          (run),
        .progWrite    (progWrite),
        .progAddr     (progAddr),
        .progData     (progData),
        .pc           (pc),
        .memWrite     (memWrite),
        .memAddr      (memAddr),
        .memWriteData (memWriteData)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;  // 4 ns period
    end

    // Galois LFSR x^8+x^6+x^5+x^4+1 stepped once per bit taken
    function automatic logic [7:0] randBits(int n);
        logic [7:0] v;
        logic       outBit;
        v = '0;
        for (int i = 0; i < n; i++) begin
            outBit = lfsr[0];
            lfsr   = (lfsr >> 1) ^ (outBit ? 8'hB8 : 8'h00);
            v      = {v[6:0], outBit};
        end
        return v;
    endfunction

    // I-format fields op, src1, src2, imm
    function automatic logic [vsaPkg::instrWidth-1:0] encodeImm(vsaPkg::opcodeT op, int s1,
                                                               int s2, logic [4:0] imm);
        return {op, 2'(s1), 2'(s2), imm};
    endfunction

    // R-format fields op, src1, src2, dst, func
    function automatic logic [vsaPkg::instrWidth-1:0] encodeReg(vsaPkg::aluFuncT fn, int s1,
                                                               int s2, int d);
        return {vsaPkg::opAlu, 2'(s1), 2'(s2), 2'(d), fn};
    endfunction

    task automatic reportMismatch(string msg);
        $display("** Error at %0t: %s", $time, msg);
        valueErrs++;
    endtask

    task automatic reportProblem(string msg);
        $display("%s", msg);
        seqErrs++;
    endtask

    task automatic buildTable();
        vsaPkg::aluFuncT fnList [8];
        logic [4:0]      x;
        logic [4:0]      y;
        fnList = '{vsaPkg::fnAdd, vsaPkg::fnSub, vsaPkg::fnAnd, vsaPkg::fnOr,
                   vsaPkg::fnXor, vsaPkg::fnNot, vsaPkg::fnSrl, vsaPkg::fnSra};
        for (int r = 0; r < numRows; r++) begin
            for (int w = 0; w < progWords; w++) begin
                progTable[r][w] = encodeImm(vsaPkg::opBeqz, 0, 0, 5'h0F);  // branch to self
            end
        end
        // row 0 runs ADDI, SUBI, then add/sub/and/or/xor stored to 0..4
        x = 5'(randBits(5));
        y = 5'(randBits(5));
        progTable[0][0] = encodeImm(vsaPkg::opAddi, 0, 1, x);
        progTable[0][1] = encodeImm(vsaPkg::opSubi, 0, 2, y);
        for (int i = 0; i < 5; i++) begin
            progTable[0][2 + 2 * i] = encodeReg(fnList[i], 1, 2, 3);
            progTable[0][3 + 2 * i] = encodeImm(vsaPkg::opSw, 0, 3, 5'(i));
        end
        // row 1 has not/srl/sra on a likely negative value and SUBI, ADDI off registers
        x = 5'(randBits(5));
        y = 5'(randBits(5));
        progTable[1][0] = encodeImm(vsaPkg::opSubi, 0, 1, x);
        progTable[1][1] = encodeImm(vsaPkg::opAddi, 0, 2, y);
        for (int i = 0; i < 3; i++) begin
            progTable[1][2 + 2 * i] = encodeReg(fnList[5 + i], 1, 2, 3);
            progTable[1][3 + 2 * i] = encodeImm(vsaPkg::opSw, 0, 3, 5'(8 + i));
        end
        x = 5'(randBits(5));
        progTable[1][8]  = encodeImm(vsaPkg::opSubi, 2, 3, x);
        progTable[1][9]  = encodeImm(vsaPkg::opSw, 0, 3, 5'd11);
        progTable[1][10] = encodeImm(vsaPkg::opAddi, 1, 3, x);
        progTable[1][11] = encodeImm(vsaPkg::opSw, 0, 3, 5'd12);
        // row 2 stores then loads back, plus a load of untouched word 25
        x = 5'(randBits(5));
        y = 5'(randBits(3));                                    // base 0..7
        progTable[2][0] = encodeImm(vsaPkg::opAddi, 0, 1, x);
        progTable[2][1] = encodeImm(vsaPkg::opAddi, 0, 2, y);
        progTable[2][2] = encodeImm(vsaPkg::opSw, 2, 1, 5'd3);
        progTable[2][3] = encodeImm(vsaPkg::opLw, 2, 3, 5'd3);
        progTable[2][4] = encodeImm(vsaPkg::opSw, 0, 3, 5'd20);
        progTable[2][5] = encodeImm(vsaPkg::opLw, 0, 3, 5'd25);
        progTable[2][6] = encodeImm(vsaPkg::opSw, 0, 3, 5'd21);
        // row 3 has a BEQZ fall-through and then two taken skips
        x = 5'(randBits(5)) | 5'd1;                             // never zero
        progTable[3][0] = encodeImm(vsaPkg::opAddi, 0, 1, x);
        progTable[3][1] = encodeImm(vsaPkg::opBeqz, 1, 0, 5'd2);  // not taken
        progTable[3][2] = encodeImm(vsaPkg::opSw, 0, 1, 5'd1);
        progTable[3][3] = encodeImm(vsaPkg::opBeqz, 0, 0, 5'd1);  // skips word 4
        progTable[3][4] = encodeImm(vsaPkg::opSw, 0, 1, 5'd2);
        progTable[3][5] = encodeImm(vsaPkg::opSw, 0, 1, 5'd3);
        progTable[3][6] = encodeImm(vsaPkg::opBeqz, 0, 0, 5'd3);  // skips 7..9
        for (int i = 0; i < 3; i++) begin
            progTable[3][7 + i] = encodeImm(vsaPkg::opSw, 0, 1, 5'(4 + i));
        end
        progTable[3][10] = encodeImm(vsaPkg::opSw, 0, 1, 5'd7);
        // row 4 aims ADDI, ADD and LW at r0
        x = 5'(randBits(5)) | 5'd1;
        y = 5'(randBits(5)) | 5'd1;
        progTable[4][0] = encodeImm(vsaPkg::opAddi, 0, 0, x);
        progTable[4][1] = encodeImm(vsaPkg::opAddi, 0, 1, y);
        progTable[4][2] = encodeReg(vsaPkg::fnAdd, 1, 1, 0);
        progTable[4][3] = encodeImm(vsaPkg::opSw, 0, 0, 5'd9);
        progTable[4][4] = encodeImm(vsaPkg::opSw, 0, 1, 5'd4);
        progTable[4][5] = encodeImm(vsaPkg::opLw, 0, 0, 5'd4);
        progTable[4][6] = encodeImm(vsaPkg::opSw, 0, 0, 5'd5);
    endtask

    // instruction-level model stepping one instruction at a time until a self branch
    task automatic modelRow(int r);
        logic [4:0]     regs [4];
        logic [4:0]     mem [32];
        logic [4:0]     mpc;
        logic [4:0]     npc;
        logic [11:0]    w;
        vsaPkg::opcodeT op;
        logic [1:0]     s1;
        logic [1:0]     s2;
        logic [1:0]     d;
        logic [2:0]     fn;
        logic [4:0]     imm;
        logic [4:0]     a;
        logic [4:0]     b;
        logic [4:0]     res;
        logic [4:0]     addr;
        logic           halted;
        expAddr.delete();
        expData.delete();
        expCycle.delete();
        regs = '{default: '0};
        mem = '{default: '0};
        mpc = '0;
        halted = 1'b0;
        execCount = 0;
        for (int k = 0; k < progWords; k++) begin
            w   = progTable[r][mpc[4:1]];
            op  = vsaPkg::opcodeT'(w[11:9]);
            s1  = w[8:7];
            s2  = w[6:5];
            d   = w[4:3];
            fn  = w[2:0];
            imm = w[4:0];
            a   = regs[s1];
            b   = regs[s2];
            npc = mpc + 5'd2;
            execCount = k + 1;
            case (op)
                vsaPkg::opLw: begin
                    addr = a + imm;
                    if (s2 != 0) regs[s2] = mem[addr];
                end
                vsaPkg::opSw: begin
                    addr = a + imm;
                    mem[addr] = b;
                    expAddr.push_back(addr);
                    expData.push_back(b);
                    expCycle.push_back(5 * k + 3);      // memory state of instr k
                end
                vsaPkg::opBeqz: if (a == 0) npc = npc + {imm[3:0], 1'b0};
                vsaPkg::opAlu: begin
                    case (fn)
                        3'd0: res = a + b;
                        3'd1: res = a - b;
                        3'd2: res = a & b;
                        3'd3: res = a | b;
                        3'd4: res = a ^ b;
                        3'd5: res = ~a;
                        3'd6: res = a >> 1;
                        default: res = 5'($signed(a) >>> 1);
                    endcase
                    if (d != 0) regs[d] = res;
                end
                vsaPkg::opAddi: if (s2 != 0) regs[s2] = a + imm;
                vsaPkg::opSubi: if (s2 != 0) regs[s2] = a - imm;
                default: ;
            endcase
            if (npc == mpc) begin
                halted = 1'b1;
                haltPc = mpc;
                break;
            end
            mpc = npc;
        end
        if (!halted) reportProblem($sformatf("row %0d: model found no halt loop", r));
    endtask

    task automatic runRow(int r);
        int cyc;
        int idx;
        int total;
        @(posedge clock);
        #1;
        rst = 1'b1;
        run = 1'b0;
        repeat (10) @(posedge clock);
        #1;
        rst = 1'b0;
        // load with run low while the core stays parked at pc 0
        for (int w = 0; w < progWords; w++) begin
            checks++;
            if (pc !== '0) reportMismatch($sformatf("row %0d: pc %0d with run low", r, pc));
            if (memWrite !== 1'b0) reportProblem($sformatf("row %0d: store while run low", r));
            progWrite = 1'b1;
            progAddr  = w[vsaPkg::progAddrWidth-1:0];
            progData  = progTable[r][w];
            @(posedge clock);
            #1;
        end
        progWrite = 1'b0;
        run = 1'b1;
        cyc = 0;
        idx = 0;
        total = (execCount + tailInstr) * 5;
        while (cyc < total) begin
            @(posedge clock);
            cyc++;                                      // cycles since run rose
            @(negedge clock);
            if (memWrite === 1'b1) begin
                if (idx >= expAddr.size()) begin
                    reportProblem($sformatf("row %0d: extra store to address %0d at cycle %0d",
                                            r, memAddr, cyc));
                end else begin
                    checks++;
                    if (memAddr !== expAddr[idx] || memWriteData !== expData[idx]) begin
                        reportMismatch($sformatf(
                            "row %0d store %0d: got %0d at %0d, want %0d at %0d",
                            r, idx, memWriteData, memAddr, expData[idx], expAddr[idx]));
                    end
                    if (cyc != expCycle[idx]) begin
                        reportMismatch($sformatf("row %0d store %0d: cycle %0d, want %0d",
                                                 r, idx, cyc, expCycle[idx]));
                    end
                    idx++;
                end
            end
        end
        if (idx < expAddr.size()) begin
            reportProblem($sformatf("row %0d: %0d expected stores never came", r,
                                    expAddr.size() - idx));
        end
        checks++;
        if (pc !== haltPc) begin
            reportMismatch($sformatf("row %0d: final pc %0d, want %0d", r, pc, haltPc));
        end
    endtask

    initial begin
        rst       = 1'b1;
        run       = 1'b0;
        progWrite = 1'b0;
        progAddr  = '0;
        progData  = '0;
        lfsr      = 8'd30;
        buildTable();
        for (int r = 0; r < numRows; r++) begin
            modelRow(r);
            runRow(r);
        end
        assertErrs = vsaSystem_i.vsaCore_i.props_i.assertFails;
        $display("checks %0d, value errors %0d, sequence errors %0d, assertion failures %0d",
                 checks, valueErrs, seqErrs, assertErrs);
        if (valueErrs + seqErrs + assertErrs == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    // watchdog sized for 16 instructions per row plus reset and load
    initial begin
        #(watchdogNs);
        $display("timeout: run did not finish within %0d ns", watchdogNs);
        $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire
